// File: sda_kernel_ctrl.f
design/kernel_ctrl_pkg.sv
design/axil_reg_slave.sv
design/kernel_ctrl_regs.sv
design/kernel_run_fsm.sv
design/reset_holdoff_timer.sv
design/kernel_param_mem.sv
design/sda_kernel_ctrl.sv
tests/sda_kernel_ctrl_assert.sv
tests/sda_kernel_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds and runs the sda_kernel_ctrl simulation with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sda_kernel_ctrl.f \
  --top-module sda_kernel_ctrl_tb -o sda_kernel_ctrl_sim --Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "Build failed with status $status"
  exit $status
fi

./obj_dir/sda_kernel_ctrl_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
fi
exit $status

// File: tests/sda_kernel_ctrl_tb.sv
module sda_kernel_ctrl_tb import kernel_ctrl_pkg::*; ();

  // Limit covers all tests with a wide margin.
  localparam int MAX_CYCLES = 5000;
  localparam int WAIT_LIMIT = 50;
  localparam reg_data_t CTRL_IDLE = 32'h4;
  localparam reg_data_t CTRL_DONE_IDLE = 32'h6;

  logic ap_clk = 1'b0;
  logic rst;
  ctrl_addr_t awaddr, araddr;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  reg_data_t wdata, rdata, param_data;
  reg_strb_t wstrb;
  axi_resp_t bresp, rresp;
  logic interrupt, kernel_rst, go_valid, go_ready, done_valid, done_ready;
  logic param_addr_valid, param_addr_ready, param_data_valid, param_data_ready;
  param_idx_t param_addr;
  string test_name;
  int cycles;

  sda_kernel_ctrl i_sda_kernel_ctrl (.*);

  always #50 ap_clk = ~ap_clk;

  always @(posedge ap_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) stop_with_failure("Timeout: run exceeded cycle limit");
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input string what, input reg_data_t exp, input reg_data_t act);
    if (exp !== act) begin
      $display("Error in %s: %s expected %h actual %h", test_name, what, exp, act);
      stop_with_failure("Data mismatch");
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (exp !== act) begin
      $display("Error in %s: %s expected %b actual %b", test_name, what, exp, act);
      stop_with_failure("Signal mismatch");
    end
  endtask

  task automatic check_resp(input string what, input axi_resp_t exp, input axi_resp_t act);
    if (exp !== act) begin
      $display("Error in %s: %s expected %h actual %h", test_name, what, exp, act);
      stop_with_failure("Response mismatch");
    end
  endtask

  // Readies are sampled a quarter period after the falling edge.
  task automatic issue_write(input ctrl_addr_t addr, input reg_data_t data, input reg_strb_t strb);
    int n;
    n = 0;
    awaddr = addr;
    wdata = data;
    wstrb = strb;
    awvalid = 1'b1;
    wvalid = 1'b1;
    #25;
    while (!(awready && wready)) begin
      @(negedge ap_clk);
      n++;
      if (n > WAIT_LIMIT) stop_with_failure("Write address/data never accepted");
      #25;
    end
    @(negedge ap_clk);
    awvalid = 1'b0;
    wvalid = 1'b0;
    bready = 1'b1;
  endtask

  task automatic host_write(input ctrl_addr_t addr, input reg_data_t data, input reg_strb_t strb);
    int n;
    n = 0;
    issue_write(addr, data, strb);
    while (!bvalid) begin
      @(negedge ap_clk);
      n++;
      if (n > WAIT_LIMIT) stop_with_failure("Write response never arrived");
    end
    check_resp("bresp", AXI_RESP_OKAY, bresp);
    @(negedge ap_clk);
    bready = 1'b0;
  endtask

  task automatic host_read(input ctrl_addr_t addr, output reg_data_t data);
    int n;
    n = 0;
    araddr = addr;
    arvalid = 1'b1;
    #25;
    while (!arready) begin
      @(negedge ap_clk);
      n++;
      if (n > WAIT_LIMIT) stop_with_failure("Read address never accepted");
      #25;
    end
    @(negedge ap_clk);
    arvalid = 1'b0;
    rready = 1'b1;
    while (!rvalid) begin
      @(negedge ap_clk);
      n++;
      if (n > WAIT_LIMIT) stop_with_failure("Read data never arrived");
    end
    data = rdata;
    check_resp("rresp", AXI_RESP_OKAY, rresp);
    @(negedge ap_clk);
    rready = 1'b0;
  endtask

  task automatic read_expect(input string what, input ctrl_addr_t addr, input reg_data_t exp);
    reg_data_t got;
    host_read(addr, got);
    check_data(what, exp, got);
  endtask

  // Starts a run, times the kernel reset, then plays the kernel.
  task automatic run_kernel;
    int n;
    logic b_seen;
    n = 1;
    b_seen = 1'b0;
    issue_write(ADDR_AP_CTRL, 32'h1, 4'hF);
    // Request and acknowledge cycles, leaving idle, then the hold-off.
    while (!go_valid) begin
      check_bit("kernel_rst during hold-off", 1'b1, kernel_rst);
      if (bvalid) begin
        b_seen = 1'b1;
        check_resp("bresp", AXI_RESP_OKAY, bresp);
      end
      @(negedge ap_clk);
      n++;
      if (n > WAIT_LIMIT) stop_with_failure("go_valid never raised");
    end
    bready = 1'b0;
    check_bit("start write response", 1'b1, b_seen);
    check_data("cycles to go_valid", reg_data_t'(KERNEL_RESET_CYCLES + 3), reg_data_t'(n));
    check_bit("kernel_rst at go", 1'b0, kernel_rst);
    go_ready = 1'b1;
    @(negedge ap_clk);
    go_ready = 1'b0;
    repeat ($urandom_range(3, 12)) @(negedge ap_clk);
    done_valid = 1'b1;
    n = 0;
    while (!done_ready) begin
      @(negedge ap_clk);
      n++;
      if (n > WAIT_LIMIT) stop_with_failure("done_ready never raised");
    end
    @(negedge ap_clk);
    done_valid = 1'b0;
  endtask

  task automatic test_reset_state;
    test_name = "reset_state";
    check_bit("interrupt", 1'b0, interrupt);
    check_bit("go_valid", 1'b0, go_valid);
    check_bit("kernel_rst", 1'b1, kernel_rst);
    read_expect("ap_ctrl", ADDR_AP_CTRL, CTRL_IDLE);
  endtask

  task automatic test_param_mem;
    param_idx_t idx [8];
    reg_data_t exp [8];
    reg_data_t word;
    int n;
    test_name = "param_mem";
    for (int i = 0; i < 8; i++) begin
      idx[i] = param_idx_t'(i * 8 + $urandom_range(0, 7));
      exp[i] = reg_data_t'($urandom());
      host_write(ctrl_addr_t'(PARAM_BASE + 4 * idx[i]), exp[i], 4'hF);
    end
    // Partial write through an aliased address, lanes 0 and 2 only.
    word = reg_data_t'($urandom());
    host_write(ctrl_addr_t'(PARAM_BASE + 12'h100 + 4 * idx[3]), word, 4'b0101);
    exp[3] = {exp[3][31:24], word[23:16], exp[3][15:8], word[7:0]};
    for (int i = 0; i < 8; i++) begin
      read_expect("host readback", ctrl_addr_t'(PARAM_BASE + 4 * idx[i]), exp[i]);
    end
    // First address goes into the empty output register.
    param_addr = idx[0];
    param_addr_valid = 1'b1;
    n = 0;
    #25;
    while (!param_addr_ready) begin
      @(negedge ap_clk);
      n++;
      if (n > WAIT_LIMIT) stop_with_failure("param_addr_ready never raised");
      #25;
    end
    @(negedge ap_clk);
    for (int i = 0; i < 8; i++) begin
      // The next address waits behind the held word.
      if (i < 7) begin
        param_addr = idx[i + 1];
      end else begin
        param_addr_valid = 1'b0;
      end
      // Data must stay put while the kernel holds ready low.
      forever begin
        check_bit("param_data_valid", 1'b1, param_data_valid);
        check_data("kernel stream", exp[i], param_data);
        param_data_ready = ($urandom_range(0, 2) == 0);
        #25;
        // A full output register takes an address only while it drains.
        check_bit("param_addr_ready", param_data_ready, param_addr_ready);
        @(negedge ap_clk);
        if (param_data_ready) break;
      end
    end
    param_data_ready = 1'b0;
  endtask

  task automatic test_run_sequence;
    test_name = "run_sequence";
    run_kernel();
    read_expect("ap_ctrl after run", ADDR_AP_CTRL, CTRL_DONE_IDLE);
    read_expect("ap_ctrl second read", ADDR_AP_CTRL, CTRL_IDLE);
  endtask

  task automatic test_interrupt;
    test_name = "interrupt";
    host_write(ADDR_GIE, 32'h1, 4'hF);
    host_write(ADDR_IER, 32'h1, 4'hF);
    run_kernel();
    check_bit("interrupt after run", 1'b1, interrupt);
    read_expect("isr", ADDR_ISR, 32'h1);
    host_write(ADDR_ISR, 32'h1, 4'hF);
    check_bit("interrupt after clear", 1'b0, interrupt);
    read_expect("isr after clear", ADDR_ISR, 32'h0);
    host_write(ADDR_IER, 32'h0, 4'hF);
    run_kernel();
    check_bit("interrupt with ier clear", 1'b0, interrupt);
    read_expect("isr with ier clear", ADDR_ISR, 32'h0);
    read_expect("ap_ctrl", ADDR_AP_CTRL, CTRL_DONE_IDLE);
  endtask

  task automatic test_unmapped;
    test_name = "unmapped";
    read_expect("offset 0x010", 12'h010, 32'h0);
    read_expect("offset 0x100", 12'h100, 32'h0);
    read_expect("offset 0x7fc", 12'h7FC, 32'h0);
    host_write(12'h010, 32'hFFFF_FFFF, 4'hF);
    host_write(12'h7FC, 32'hFFFF_FFFF, 4'hF);
    read_expect("offset 0x010 after write", 12'h010, 32'h0);
    read_expect("gie", ADDR_GIE, 32'h1);
    read_expect("ier", ADDR_IER, 32'h0);
    read_expect("isr", ADDR_ISR, 32'h0);
    read_expect("ap_ctrl", ADDR_AP_CTRL, CTRL_IDLE);
  endtask

  initial begin
    void'($urandom(81231));
    cycles = 0;
    rst = 1'b1;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    go_ready = 1'b0;
    done_valid = 1'b0;
    param_addr_valid = 1'b0;
    param_addr = '0;
    param_data_ready = 1'b0;
    repeat (2) @(negedge ap_clk);
    rst = 1'b0;
    @(negedge ap_clk);
    test_reset_state();
    test_param_mem();
    test_run_sequence();
    test_interrupt();
    test_unmapped();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: tests/sda_kernel_ctrl_assert.sv
module sda_kernel_ctrl_assert import kernel_ctrl_pkg::*; (
  input logic       ap_clk,
  input logic       rst,
  input ctrl_addr_t awaddr,
  input logic       awvalid,
  input logic       awready,
  input reg_data_t  wdata,
  input logic       bvalid,
  input logic       bready,
  input logic       rvalid,
  input logic       rready,
  input logic       go_valid,
  input logic       kernel_rst,
  input logic       interrupt
);

  logic gie_written;

  // Remembers a host write of 1 to the global interrupt enable.
  always_ff @(posedge ap_clk) begin
    if (rst) begin
      gie_written <= 1'b0;
    end else if (awvalid && awready && (awaddr == ADDR_GIE) && wdata[0]) begin
      gie_written <= 1'b1;
    end
  end

  bvalid_hold: assert property (@(posedge ap_clk) disable iff (rst)
    bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");

  rvalid_hold: assert property (@(posedge ap_clk) disable iff (rst)
    rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

  go_out_of_reset: assert property (@(posedge ap_clk) disable iff (rst)
    !(go_valid && kernel_rst)) else $error("go_valid high while kernel held in reset");

  irq_needs_gie: assert property (@(posedge ap_clk) disable iff (rst)
    interrupt |-> gie_written) else $error("interrupt raised without GIE written");

endmodule

bind sda_kernel_ctrl sda_kernel_ctrl_assert i_sda_kernel_ctrl_assert (.*);

// File: design/sda_kernel_ctrl.sv
module sda_kernel_ctrl import kernel_ctrl_pkg::*; (
  input  logic       ap_clk,
  input  logic       rst,
  input  ctrl_addr_t awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  reg_data_t  wdata,
  input  reg_strb_t  wstrb,
  input  logic       wvalid,
  output logic       wready,
  output axi_resp_t  bresp,
  output logic       bvalid,
  input  logic       bready,
  input  ctrl_addr_t araddr,
  input  logic       arvalid,
  output logic       arready,
  output reg_data_t  rdata,
  output axi_resp_t  rresp,
  output logic       rvalid,
  input  logic       rready,
  output logic       interrupt,
  output logic       kernel_rst,
  output logic       go_valid,
  input  logic       go_ready,
  input  logic       done_valid,
  output logic       done_ready,
  input  logic       param_addr_valid,
  output logic       param_addr_ready,
  input  param_idx_t param_addr,
  output logic       param_data_valid,
  input  logic       param_data_ready,
  output reg_data_t  param_data
);

  // Register bus between the AXI-lite slave and its targets.
  logic       reg_req;
  logic       reg_write_en;
  ctrl_addr_t reg_addr;
  reg_data_t  reg_wdata;
  reg_strb_t  reg_wstrb;
  logic       reg_ack;
  reg_data_t  reg_rdata;
  logic       ctrl_ack;
  reg_data_t  ctrl_rdata;
  logic       param_ack;
  reg_data_t  param_rdata;

  // Run control.
  logic start_pending;
  logic start_taken;
  logic run_done;
  logic run_idle;
  logic holdoff_start;
  logic holdoff_done;

  axil_reg_slave axil_slave_u (
    .ap_clk, .rst,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
    .rdata, .rresp, .rvalid, .rready,
    .reg_req, .reg_write_en, .reg_addr, .reg_wdata, .reg_wstrb,
    .reg_ack, .reg_rdata
  );

  kernel_ctrl_regs ctrl_regs_u (
    .ap_clk, .rst,
    .reg_req, .reg_write_en, .reg_addr, .reg_wdata, .reg_wstrb,
    .reg_ack(ctrl_ack), .reg_rdata(ctrl_rdata),
    .start_pending, .start_taken, .run_done, .run_idle, .interrupt
  );

  kernel_param_mem param_mem_u (
    .ap_clk, .rst,
    .reg_req, .reg_write_en, .reg_addr, .reg_wdata, .reg_wstrb,
    .reg_ack(param_ack), .reg_rdata(param_rdata),
    .param_addr_valid, .param_addr_ready, .param_addr,
    .param_data_valid, .param_data_ready, .param_data
  );

  kernel_run_fsm run_fsm_u (
    .ap_clk, .rst,
    .start_pending, .start_taken, .run_done, .run_idle,
    .holdoff_start, .holdoff_done,
    .kernel_rst, .go_valid, .go_ready, .done_valid, .done_ready
  );

  reset_holdoff_timer holdoff_timer_u (
    .ap_clk, .rst, .holdoff_start, .holdoff_done
  );

  // Targets that are not addressed return zero, so a plain OR merges them.
  assign reg_ack = ctrl_ack | param_ack;
  assign reg_rdata = ctrl_rdata | param_rdata;

endmodule

// File: design/kernel_param_mem.sv
module kernel_param_mem import kernel_ctrl_pkg::*; (
  input  logic       ap_clk,
  input  logic       rst,
  input  logic       reg_req,
  input  logic       reg_write_en,
  input  ctrl_addr_t reg_addr,
  input  reg_data_t  reg_wdata,
  input  reg_strb_t  reg_wstrb,
  output logic       reg_ack,
  output reg_data_t  reg_rdata,
  input  logic       param_addr_valid,
  output logic       param_addr_ready,
  input  param_idx_t param_addr,
  output logic       param_data_valid,
  input  logic       param_data_ready,
  output reg_data_t  param_data
);

  reg_data_t  mem [PARAM_WORDS];
  logic       sel;
  logic       kernel_rd;
  param_idx_t host_idx;

  assign sel = reg_req && (reg_addr >= PARAM_BASE);
  // Upper address bits are ignored, so the window repeats every 256 bytes.
  assign host_idx = reg_addr[PARAM_IDX_WIDTH+1:2];

  // Output register accepts a new address when empty or being drained.
  assign param_addr_ready = !param_data_valid || param_data_ready;
  assign kernel_rd = param_addr_valid && param_addr_ready;

  always_ff @(posedge ap_clk) begin
    if (sel && reg_write_en) begin
      for (int b = 0; b < REG_STRB_WIDTH; b++) begin
        if (reg_wstrb[b]) mem[host_idx][8*b +: 8] <= reg_wdata[8*b +: 8];
      end
    end
    reg_rdata <= (sel && !reg_write_en) ? mem[host_idx] : '0;
    // Reads see the word as it was before a same-cycle host write.
    if (kernel_rd) param_data <= mem[param_addr];
  end

  always_ff @(posedge ap_clk) begin
    if (rst) begin
      reg_ack <= 1'b0;
      param_data_valid <= 1'b0;
    end else begin
      reg_ack <= sel;
      if (kernel_rd) begin
        param_data_valid <= 1'b1;
      end else if (param_data_ready) begin
        param_data_valid <= 1'b0;
      end
    end
  end

endmodule

// File: design/reset_holdoff_timer.sv
module reset_holdoff_timer import kernel_ctrl_pkg::*; (
  input  logic ap_clk,
  input  logic rst,
  input  logic holdoff_start,
  output logic holdoff_done
);

  holdoff_count_t count;

  // Loading one less than the window length puts zero in its last cycle.
  always_ff @(posedge ap_clk) begin
    if (rst) begin
      count <= '0;
    end else if (holdoff_start) begin
      count <= holdoff_count_t'(KERNEL_RESET_CYCLES - 1);
    end else if (count != '0) begin
      count <= count - 1'b1;
    end
  end

  assign holdoff_done = (count == '0);

endmodule

// File: design/kernel_run_fsm.sv
module kernel_run_fsm import kernel_ctrl_pkg::*; (
  input  logic ap_clk,
  input  logic rst,
  input  logic start_pending,
  output logic start_taken,
  output logic run_done,
  output logic run_idle,
  output logic holdoff_start,
  input  logic holdoff_done,
  output logic kernel_rst,
  output logic go_valid,
  input  logic go_ready,
  input  logic done_valid,
  output logic done_ready
);

  run_state_t state;

  always_ff @(posedge ap_clk) begin
    if (rst) begin
      state <= RUN_IDLE;
    end else begin
      case (state)
        RUN_IDLE: begin
          if (start_pending) state <= RUN_RESET;
        end
        // Kernel stays in reset until the timer expires.
        RUN_RESET: begin
          if (holdoff_done) state <= RUN_GO;
        end
        RUN_GO: begin
          if (go_ready) state <= RUN_BUSY;
        end
        RUN_BUSY: begin
          if (done_valid) state <= RUN_IDLE;
        end
        default: state <= RUN_IDLE;
      endcase
    end
  end

  assign start_taken = (state == RUN_IDLE) && start_pending;
  assign holdoff_start = start_taken;
  assign run_done = (state == RUN_BUSY) && done_valid;
  assign run_idle = (state == RUN_IDLE);

  // The kernel is only released once a run is under way.
  assign kernel_rst = (state == RUN_IDLE) || (state == RUN_RESET);
  assign go_valid = (state == RUN_GO);
  assign done_ready = (state == RUN_BUSY);

endmodule

// File: design/kernel_ctrl_regs.sv
module kernel_ctrl_regs import kernel_ctrl_pkg::*; (
  input  logic       ap_clk,
  input  logic       rst,
  input  logic       reg_req,
  input  logic       reg_write_en,
  input  ctrl_addr_t reg_addr,
  input  reg_data_t  reg_wdata,
  input  reg_strb_t  reg_wstrb,
  output logic       reg_ack,
  output reg_data_t  reg_rdata,
  output logic       start_pending,
  input  logic       start_taken,
  input  logic       run_done,
  input  logic       run_idle,
  output logic       interrupt
);

  logic      ap_start;
  logic      ap_done;
  logic      gie;
  logic      ier;
  logic      isr;
  logic      sel;
  logic      wr_bit0;
  logic      rd;
  reg_data_t rdata_next;

  assign sel = reg_req && (reg_addr < PARAM_BASE);
  // Every register lives in byte lane 0.
  assign wr_bit0 = sel && reg_write_en && reg_wstrb[0];
  assign rd = sel && !reg_write_en;

  always_comb begin
    rdata_next = '0;
    if (rd) begin
      case (reg_addr)
        ADDR_AP_CTRL: rdata_next[2:0] = {run_idle, ap_done, ap_start};
        ADDR_GIE:     rdata_next[0] = gie;
        ADDR_IER:     rdata_next[0] = ier;
        ADDR_ISR:     rdata_next[0] = isr;
        default:      rdata_next = '0;
      endcase
    end
  end

  always_ff @(posedge ap_clk) begin
    if (rst) begin
      reg_ack <= 1'b0;
      ap_start <= 1'b0;
      ap_done <= 1'b0;
      gie <= 1'b0;
      ier <= 1'b0;
      isr <= 1'b0;
    end else begin
      reg_ack <= sel;

      // A fresh start request is kept even if the FSM takes one now.
      if (wr_bit0 && (reg_addr == ADDR_AP_CTRL) && reg_wdata[0]) begin
        ap_start <= 1'b1;
      end else if (start_taken) begin
        ap_start <= 1'b0;
      end

      // Done is sticky until the host reads the control register.
      if (run_done) begin
        ap_done <= 1'b1;
      end else if (rd && (reg_addr == ADDR_AP_CTRL)) begin
        ap_done <= 1'b0;
      end

      if (wr_bit0 && (reg_addr == ADDR_GIE)) gie <= reg_wdata[0];
      if (wr_bit0 && (reg_addr == ADDR_IER)) ier <= reg_wdata[0];

      if (run_done && ier) begin
        isr <= 1'b1;
      end else if (wr_bit0 && (reg_addr == ADDR_ISR) && reg_wdata[0]) begin
        isr <= ~isr;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    reg_rdata <= rdata_next;
  end

  // The run FSM sees the start bit until it takes the run.
  assign start_pending = ap_start;
  assign interrupt = gie & isr;

endmodule

// File: design/axil_reg_slave.sv
module axil_reg_slave import kernel_ctrl_pkg::*; (
  input  logic       ap_clk,
  input  logic       rst,
  input  ctrl_addr_t awaddr,
  input  logic       awvalid,
  output logic       awready,
  input  reg_data_t  wdata,
  input  reg_strb_t  wstrb,
  input  logic       wvalid,
  output logic       wready,
  output axi_resp_t  bresp,
  output logic       bvalid,
  input  logic       bready,
  input  ctrl_addr_t araddr,
  input  logic       arvalid,
  output logic       arready,
  output reg_data_t  rdata,
  output axi_resp_t  rresp,
  output logic       rvalid,
  input  logic       rready,
  output logic       reg_req,
  output logic       reg_write_en,
  output ctrl_addr_t reg_addr,
  output reg_data_t  reg_wdata,
  output reg_strb_t  reg_wstrb,
  input  logic       reg_ack,
  input  reg_data_t  reg_rdata
);

  typedef enum logic [2:0] {
    AXIL_IDLE,
    AXIL_REQ,
    AXIL_ACK,
    AXIL_BRESP,
    AXIL_RRESP
  } axil_state_t;

  axil_state_t state;
  logic        take_write;
  logic        take_read;

  // Writes need both address and data present, and win over a read.
  assign take_write = (state == AXIL_IDLE) && awvalid && wvalid;
  assign take_read = (state == AXIL_IDLE) && arvalid && !(awvalid && wvalid);

  assign awready = take_write;
  assign wready = take_write;
  assign arready = take_read;

  assign reg_req = (state == AXIL_REQ);

  assign bvalid = (state == AXIL_BRESP);
  assign rvalid = (state == AXIL_RRESP);
  assign bresp = AXI_RESP_OKAY;
  assign rresp = AXI_RESP_OKAY;

  always_ff @(posedge ap_clk) begin
    if (rst) begin
      state <= AXIL_IDLE;
      reg_write_en <= 1'b0;
    end else begin
      case (state)
        AXIL_IDLE: begin
          if (take_write) begin
            state <= AXIL_REQ;
            reg_write_en <= 1'b1;
          end else if (take_read) begin
            state <= AXIL_REQ;
            reg_write_en <= 1'b0;
          end
        end
        AXIL_REQ: state <= AXIL_ACK;
        // One of the targets always answers in this cycle.
        AXIL_ACK: begin
          if (reg_ack) begin
            state <= reg_write_en ? AXIL_BRESP : AXIL_RRESP;
          end
        end
        AXIL_BRESP: if (bready) state <= AXIL_IDLE;
        AXIL_RRESP: if (rready) state <= AXIL_IDLE;
        default: state <= AXIL_IDLE;
      endcase
    end
  end

  always_ff @(posedge ap_clk) begin
    if (take_write) begin
      reg_addr <= awaddr;
      reg_wdata <= wdata;
      reg_wstrb <= wstrb;
    end else if (take_read) begin
      reg_addr <= araddr;
    end
    // Read data is held for the whole R phase.
    if ((state == AXIL_ACK) && reg_ack && !reg_write_en) begin
      rdata <= reg_rdata;
    end
  end

endmodule

// File: design/kernel_ctrl_pkg.sv
package kernel_ctrl_pkg;

  // Bus widths.
  localparam int CTRL_ADDR_WIDTH = 12;
  localparam int REG_DATA_WIDTH = 32;
  localparam int REG_STRB_WIDTH = REG_DATA_WIDTH / 8;

  // Parameter memory geometry.
  localparam int PARAM_WORDS = 64;
  localparam int PARAM_IDX_WIDTH = $clog2(PARAM_WORDS);

  // Kernel reset hold-off after each start.
  localparam int HOLDOFF_WIDTH = 4;
  localparam int KERNEL_RESET_CYCLES = 8;

  typedef logic [CTRL_ADDR_WIDTH-1:0] ctrl_addr_t;
  typedef logic [REG_DATA_WIDTH-1:0] reg_data_t;
  typedef logic [REG_STRB_WIDTH-1:0] reg_strb_t;
  typedef logic [1:0] axi_resp_t;
  typedef logic [PARAM_IDX_WIDTH-1:0] param_idx_t;
  typedef logic [HOLDOFF_WIDTH-1:0] holdoff_count_t;

  // Control window is 0x000 to 0x7FF, parameter window starts here.
  localparam ctrl_addr_t PARAM_BASE = 12'h800;

  // Control register offsets.
  localparam ctrl_addr_t ADDR_AP_CTRL = 12'h000;
  localparam ctrl_addr_t ADDR_GIE = 12'h004;
  localparam ctrl_addr_t ADDR_IER = 12'h008;
  localparam ctrl_addr_t ADDR_ISR = 12'h00C;

  localparam axi_resp_t AXI_RESP_OKAY = 2'b00;

  // Kernel run sequence.
  typedef enum logic [1:0] {
    RUN_IDLE,
    RUN_RESET,
    RUN_GO,
    RUN_BUSY
  } run_state_t;

endpackage
